//--- hdl/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 256
`define ICACHE_BANKS 4

// word and address field widths
`define ICACHE_WORD_W 32
`define ICACHE_TAG_W 20
`define ICACHE_INDEX_W 8
`define ICACHE_OFFSET_W 4

// replacement lfsr start value must be nonzero
`define ICACHE_LFSR_SEED 16'hace1

`endif

//--- hdl/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    typedef logic [`ICACHE_WORD_W-1:0] word_t;
    typedef logic [$clog2(`ICACHE_BANKS)-1:0] bank_t;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // same word seen as bus address or as cache fields
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } addr_u;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic                     valid;
    } tagv_t;

    typedef struct packed {
        addr_u                             addr;
        logic                              uncached;
        logic [$clog2(`ICACHE_WAYS)-1:0]   way;     // victim
    } miss_req_t;

    typedef struct packed {
        logic [`ICACHE_INDEX_W-1:0] index;
        bank_t                      bank;
        word_t                      data;
        logic                       tag_write;
        logic [`ICACHE_TAG_W-1:0]   tag;
    } fill_t;

    typedef enum logic [2:0] {
        bus_word = 3'b010,
        bus_line = 3'b100
    } bus_type_e;

endpackage

//--- hdl/icache_sram.sv
module icache_sram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // contents start cleared, so every valid bit is low at power-up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr]; // read-first and held while en is low
        end
    end

endmodule

//--- hdl/icache_way.sv
`include "icache_cfg.svh"

module icache_way (
    input  logic                       clk,
    input  logic [`ICACHE_INDEX_W-1:0] rd_index,
    input  icache_pkg::bank_t          offset,
    input  icache_pkg::fill_t          fill,
    input  logic                       fill_en,
    output icache_pkg::tagv_t          tagv,
    output icache_pkg::word_t          word
);

    logic [`ICACHE_INDEX_W-1:0] index;
    icache_pkg::tagv_t          tag_din;
    icache_pkg::word_t          bank_dout [`ICACHE_BANKS];

    assign index = fill_en ? fill.index : rd_index; // fill owns the port during refill

    assign tag_din.tag   = fill.tag;
    assign tag_din.valid = 1'b1;

    icache_sram #(
        .WIDTH ($bits(icache_pkg::tagv_t)),
        .DEPTH (`ICACHE_SETS)
    ) tag_ram (
        .clk  (clk),
        .en   (!fill_en || fill.tag_write),
        .we   (fill_en && fill.tag_write),
        .addr (index),
        .din  (tag_din),
        .dout (tagv)
    );

    for (genvar b = 0; b < `ICACHE_BANKS; b++) begin : g_bank
        logic bank_sel;

        assign bank_sel = (fill.bank == b);

        icache_sram #(
            .WIDTH (`ICACHE_WORD_W),
            .DEPTH (`ICACHE_SETS)
        ) data_ram (
            .clk  (clk),
            .en   (!fill_en || bank_sel), // only the beat's bank moves
            .we   (fill_en && bank_sel),
            .addr (index),
            .din  (fill.data),
            .dout (bank_dout[b])
        );
    end

    assign word = bank_dout[offset];

endmodule

//--- hdl/icache_lookup.sv
`include "icache_cfg.svh"

module icache_lookup (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  icache_pkg::addr_u          addr,
    input  logic                       uncached,
    output logic                       addr_ok,
    output logic [`ICACHE_INDEX_W-1:0] rd_index,
    output icache_pkg::bank_t          word_offset,
    input  icache_pkg::tagv_t          way0_tagv,
    input  icache_pkg::tagv_t          way1_tagv,
    input  icache_pkg::word_t          way0_word,
    input  icache_pkg::word_t          way1_word,
    output logic                       hit_data_ok,
    output icache_pkg::word_t          hit_rdata,
    output logic                       miss_valid,
    output icache_pkg::miss_req_t      miss_req,
    input  logic                       refill_done
);

    typedef enum logic [1:0] {s_idle, s_lookup, s_wait} state_e;

    state_e            state;
    icache_pkg::addr_u req_addr;
    logic              req_uncached;
    logic [15:0]       lfsr;
    logic              accept;
    logic              way0_hit;
    logic              way1_hit;
    logic              hit;

    assign way0_hit = way0_tagv.valid && (way0_tagv.tag == req_addr.f.tag);
    assign way1_hit = way1_tagv.valid && (way1_tagv.tag == req_addr.f.tag);
    assign hit      = (way0_hit || way1_hit) && !req_uncached; // uncached always misses

    assign addr_ok = (state == s_idle) || (state == s_lookup && hit) ||
                     (state == s_wait && refill_done);
    assign accept  = valid && addr_ok;

    assign rd_index    = accept ? addr.f.index : req_addr.f.index;
    assign word_offset = req_addr.f.offset[`ICACHE_OFFSET_W-1:2];

    assign hit_data_ok = (state == s_lookup) && hit;
    assign hit_rdata   = way1_hit ? way1_word : way0_word;

    assign miss_valid        = (state == s_lookup) && !hit;
    assign miss_req.addr     = req_addr;
    assign miss_req.uncached = req_uncached;
    // empty way first and lfsr bit when both hold lines
    assign miss_req.way = !way0_tagv.valid ? 1'b0 :
                          !way1_tagv.valid ? 1'b1 : lfsr[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            lfsr  <= `ICACHE_LFSR_SEED;
        end else begin
            // galois lfsr x^16+x^14+x^13+x^11+1
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
            if (accept) begin
                state <= s_lookup;
            end else if (miss_valid) begin
                state <= s_wait;
            end else if (hit_data_ok || (state == s_wait && refill_done)) begin
                state <= s_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr     <= addr;
            req_uncached <= uncached;
        end
    end

endmodule

//--- hdl/icache_refill.sv
`include "icache_cfg.svh"

module icache_refill (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      miss_valid,
    input  icache_pkg::miss_req_t     miss_req,
    output logic                      rd_req,
    output icache_pkg::bus_type_e     rd_type,
    output icache_pkg::addr_u         rd_addr,
    input  logic                      rd_rdy,
    input  logic                      ret_valid,
    input  logic                      ret_last,
    input  icache_pkg::word_t         ret_data,
    output logic                      refill_data_ok,
    output icache_pkg::word_t         refill_rdata,
    output logic                      cache_miss,
    output icache_pkg::fill_t         fill,
    output logic [`ICACHE_WAYS-1:0]   fill_way_en,
    output logic                      refill_done
);

    typedef enum logic [1:0] {s_idle, s_replace, s_refill} state_e;

    state_e                state;
    icache_pkg::miss_req_t req;
    icache_pkg::bank_t     beat_cnt;
    logic                  beat;

    assign beat = (state == s_refill) && ret_valid;

    assign rd_req  = (state == s_replace);
    assign rd_type = req.uncached ? icache_pkg::bus_word : icache_pkg::bus_line;

    always_comb begin
        rd_addr = req.addr;
        if (!req.uncached) begin
            rd_addr.f.offset = '0; // line reads start at word 0
        end
    end

    // critical word goes straight to fetch
    assign refill_data_ok = beat &&
                            (req.uncached || beat_cnt == req.addr.f.offset[`ICACHE_OFFSET_W-1:2]);
    assign refill_rdata   = ret_data;
    assign cache_miss     = beat && ret_last && !req.uncached;

    assign fill.index     = req.addr.f.index;
    assign fill.bank      = beat_cnt;
    assign fill.data      = ret_data;
    assign fill.tag_write = ret_last && !req.uncached; // tag lands with the final bank
    assign fill.tag       = req.addr.f.tag;

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            fill_way_en[w] = beat && !req.uncached && (req.way == w);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= s_idle;
            beat_cnt    <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= beat && ret_last;
            case (state)
                s_idle: begin
                    if (miss_valid) begin
                        state <= s_replace;
                    end
                end
                s_replace: begin
                    if (rd_rdy) begin
                        state    <= s_refill;
                        beat_cnt <= '0;
                    end
                end
                s_refill: begin
                    if (ret_valid) begin
                        beat_cnt <= beat_cnt + 1'b1; // gaps just stall
                        if (ret_last) begin
                            state <= s_idle;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && miss_valid) begin
            req <= miss_req;
        end
    end

endmodule

//--- hdl/icache_top.sv
`include "icache_cfg.svh"

module icache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  icache_pkg::addr_u     addr,
    input  logic                  uncached,
    output logic                  addr_ok,
    output logic                  data_ok,
    output icache_pkg::word_t     rdata,
    output logic                  cache_miss,
    output logic                  rd_req,
    output icache_pkg::bus_type_e rd_type,
    output icache_pkg::addr_u     rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  icache_pkg::word_t     ret_data
);

    logic [`ICACHE_INDEX_W-1:0] rd_index;
    icache_pkg::bank_t          word_offset;
    icache_pkg::tagv_t          way0_tagv;
    icache_pkg::tagv_t          way1_tagv;
    icache_pkg::word_t          way0_word;
    icache_pkg::word_t          way1_word;
    logic                       hit_data_ok;
    icache_pkg::word_t          hit_rdata;
    logic                       miss_valid;
    icache_pkg::miss_req_t      miss_req;
    logic                       refill_done;
    logic                       refill_data_ok;
    icache_pkg::word_t          refill_rdata;
    icache_pkg::fill_t          fill;
    logic [`ICACHE_WAYS-1:0]    fill_way_en;

    assign data_ok = hit_data_ok | refill_data_ok;
    assign rdata   = hit_data_ok ? hit_rdata : refill_rdata; // never both in one cycle

    icache_lookup u_lookup (.*);

    icache_refill u_refill (.*);

    icache_way u_way0 (
        .clk      (clk),
        .rd_index (rd_index),
        .offset   (word_offset),
        .fill     (fill),
        .fill_en  (fill_way_en[0]),
        .tagv     (way0_tagv),
        .word     (way0_word)
    );

    icache_way u_way1 (
        .clk      (clk),
        .rd_index (rd_index),
        .offset   (word_offset),
        .fill     (fill),
        .fill_en  (fill_way_en[1]),
        .tagv     (way1_tagv),
        .word     (way1_word)
    );

endmodule

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end
endmodule

//--- tb/icache_chk.sv
module icache_chk (
    input logic                  clk,
    input logic                  reset,
    input logic                  rd_req,
    input icache_pkg::bus_type_e rd_type,
    input logic                  rd_rdy,
    input icache_pkg::addr_u     rd_addr,
    input logic                  ret_valid,
    input logic                  ret_last,
    input logic                  cache_miss,
    input logic                  data_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    logic line_rd; // bus transfer in flight is a line read

    always_ff @(posedge clk) begin
        if (reset) begin
            line_rd <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            line_rd <= (rd_type == icache_pkg::bus_line);
        end
    end

    // read request waits for rd_rdy with a steady address
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else $error("rd_req dropped or rd_addr moved before rd_rdy");

    a_miss_on_last: assert property (@(posedge clk) disable iff (reset)
        cache_miss == (ret_valid && ret_last && line_rd))
        else $error("cache_miss does not match the last beat of a line read");

    a_no_data_on_req: assert property (@(posedge clk) disable iff (reset)
        !(data_ok && rd_req))
        else $error("data_ok while a bus read is still pending");
endmodule

//--- tb/icache_tb.sv
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_req = 400;
    localparam logic [7:0] index_pool [4] = '{8'h00, 8'h5c, 8'ha3, 8'hff};
    localparam logic [19:0] tag_pool [3] = '{20'h00000, 20'h8f0c1, 20'hffff7};

    typedef struct packed {
        icache_pkg::addr_u addr;
        logic              unc;
        logic [1:0]        isel;
        logic [1:0]        tsel;
        logic [31:0]       cyc;   // monitor cycle of acceptance
    } pend_t;

    logic                  clk, reset;
    logic                  valid, uncached, addr_ok, data_ok, cache_miss;
    logic                  rd_req, rd_rdy, ret_valid, ret_last;
    icache_pkg::addr_u     addr, rd_addr;
    icache_pkg::word_t     rdata, ret_data;
    icache_pkg::bus_type_e rd_type;

    pend_t      pend [$];
    int         res [4][3];  // 0 absent, 1 resident, 2 maybe resident
    int         nvalid [4];  // filled ways per index
    int         cyc;
    logic       bus_seen, bus_unc;
    logic [1:0] cur_isel, cur_tsel;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    icache_top dut (.*);

    bind icache_top icache_chk chk (.*);

    function automatic icache_pkg::word_t mem_word(icache_pkg::addr_u a);
        return (a.word * 32'h9e3779b1) ^ {a.word[15:0], a.word[31:16]};
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string what, icache_pkg::word_t got, icache_pkg::word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_addr(string what, icache_pkg::addr_u got, icache_pkg::addr_u exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                                     $time, what, got.word, exp.word));
        end
    endtask

    task automatic check_type(string what, icache_pkg::bus_type_e got,
                              icache_pkg::bus_type_e exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    // oldest request answers, then the model learns hit or miss
    task automatic take_response();
        pend_t e;
        int    n_sure;
        if (pend.size() == 0) begin
            report_failure("data_ok arrived with no request outstanding");
        end
        e = pend.pop_front();
        check_word("rdata", rdata, mem_word(e.addr));
        if (e.unc) begin
            if (!bus_seen) begin
                report_failure("uncached request was answered without a bus read");
            end
        end else if (!bus_seen) begin
            if (cyc != e.cyc + 1) begin
                report_failure("hit data_ok did not come one cycle after acceptance");
            end
            if (res[e.isel][e.tsel] == 0) begin
                report_failure("request hit a line that should not be resident");
            end
            res[e.isel][e.tsel] = 1;
            n_sure = 0;
            for (int k = 0; k < 3; k++) begin
                n_sure += (res[e.isel][k] == 1);
            end
            for (int k = 0; k < 3; k++) begin
                if (n_sure == 2 && res[e.isel][k] == 2) begin
                    res[e.isel][k] = 0; // both ways now known
                end
            end
        end else begin
            if (res[e.isel][e.tsel] == 1) begin
                report_failure("request missed a line that should be resident");
            end
            if (nvalid[e.isel] < 2) begin
                nvalid[e.isel]++; // empty way taken
            end else begin
                for (int k = 0; k < 3; k++) begin
                    if (res[e.isel][k] == 1) begin
                        res[e.isel][k] = 2;
                    end
                end
            end
            res[e.isel][e.tsel] = 1;
        end
        bus_seen = 1'b0;
    endtask

    always @(negedge clk) begin
        icache_pkg::addr_u exp_addr;
        if (!reset) begin
            cyc++;
            if (rd_req) begin
                if (pend.size() != 1) begin
                    report_failure("bus read issued without exactly one request outstanding");
                end
                exp_addr = pend[0].addr;
                if (!pend[0].unc) begin
                    exp_addr.f.offset = '0; // line aligned
                end
                check_addr("rd_addr", rd_addr, exp_addr);
                check_type("rd_type", rd_type,
                           pend[0].unc ? icache_pkg::bus_word : icache_pkg::bus_line);
                check_flag("data_ok during bus read", data_ok, 1'b0);
                bus_seen = 1'b1;
                bus_unc  = pend[0].unc;
            end
            check_flag("cache_miss", cache_miss, ret_valid && ret_last && !bus_unc);
            if (data_ok) begin
                take_response();
            end
            if (valid && addr_ok) begin
                pend.push_back(pend_t'{addr, uncached, cur_isel, cur_tsel, 32'(cyc)});
            end
        end
    end

    task automatic serve_bus();
        icache_pkg::addr_u base;
        icache_pkg::addr_u beat_addr;
        int                n_beats;
        forever begin
            @(posedge clk);
            #1;
            if (rd_req) begin
                repeat ($urandom_range(0, 3)) begin // rd_rdy held low
                    @(posedge clk);
                    #1;
                end
                rd_rdy  = 1'b1;
                base    = rd_addr;
                n_beats = (rd_type == icache_pkg::bus_line) ? 4 : 1;
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                for (int b = 0; b < n_beats; b++) begin
                    repeat ($urandom_range(0, 2)) begin // gap between beats
                        @(posedge clk);
                        #1;
                    end
                    beat_addr.word = base.word + 32'(4 * b);
                    ret_valid = 1'b1;
                    ret_last  = (b == n_beats - 1);
                    ret_data  = mem_word(beat_addr);
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    endtask

    task automatic drive_requests();
        for (int i = 0; i < n_req; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                valid = 1'b0;
                @(posedge clk);
                #1;
            end
            cur_isel      = 2'($urandom_range(0, 3));
            cur_tsel      = 2'($urandom_range(0, 2));
            addr.f.tag    = tag_pool[cur_tsel];
            addr.f.index  = index_pool[cur_isel];
            addr.f.offset = {2'($urandom_range(0, 3)), 2'b00};
            uncached      = ($urandom_range(0, 5) == 0);
            valid         = 1'b1;
            do @(negedge clk); while (!addr_ok);
            @(posedge clk);
            #1;
        end
        valid = 1'b0;
    endtask

    initial begin
        void'($urandom(97));
        valid     = 1'b0;
        addr      = '0;
        uncached  = 1'b0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        cur_isel  = '0;
        cur_tsel  = '0;
        bus_seen  = 1'b0;
        bus_unc   = 1'b0;
        cyc       = 0;
        fork
            serve_bus();
        join_none
        @(negedge reset);
        @(negedge clk);
        check_flag("addr_ok after reset", addr_ok, 1'b1);
        check_flag("data_ok after reset", data_ok, 1'b0);
        check_flag("rd_req after reset", rd_req, 1'b0);
        check_flag("cache_miss after reset", cache_miss, 1'b0);
        @(posedge clk);
        #1;
        drive_requests();
        while (pend.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(n_req * 40 * 8); // cycles per request times the clock period
        report_failure("timeout: the requests did not all complete in time");
    end
endmodule

//--- tb.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_sram.sv
hdl/icache_way.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_top.sv
tb/tb_clock.sv
tb/icache_chk.sv
tb/icache_tb.sv

//--- Makefile
SIM      := verilator
TOP      := icache_tb
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --top-module $(TOP)

BIN  := $(BUILD)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
